/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_two_way_cache
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* cache_input.txt */
# columns: op (R/W), byte address, write data, expected rd, expected hit
# all values in hex; untouched ram words read as word address ^ 5a5a0000
R 00000004 00000000 5a5a0001 0
R 00000004 00000000 5a5a0001 1
W 0000000c 11110000 11110000 0
R 0000000c 00000000 11110000 1
W 0000000c 22220000 22220000 1
R 0000000c 00000000 22220000 1
R 00000014 00000000 5a5a0005 0
R 00000054 00000000 5a5a0015 0
R 00000014 00000000 5a5a0005 1
R 00000094 00000000 5a5a0025 0
R 00000014 00000000 5a5a0005 1
R 00000054 00000000 5a5a0015 0
R 00000014 00000000 5a5a0005 1
W 00000018 55550000 55550000 0
W 00000058 66660000 66660000 0
R 00000098 00000000 5a5a0026 0
R 00000058 00000000 66660000 1
R 00000018 00000000 55550000 0
R 00000018 00000000 55550000 1
R 00000098 00000000 5a5a0026 0
R 00000058 00000000 66660000 0
R 0000004c 00000000 5a5a0013 0
R 0000008c 00000000 5a5a0023 0
R 0000000c 00000000 22220000 0
W 0000004c 77770000 77770000 0
R 0000004c 00000000 77770000 1
R 0000000c 00000000 22220000 1
W 0000000c 88880000 88880000 1
R 0000000c 00000000 88880000 1
R 10000000 00000000 5e5a0000 0
W 80000040 99990000 99990000 0
R 10000000 00000000 5e5a0000 1
R 00000000 00000000 5a5a0000 0
R 80000040 00000000 99990000 0

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int BYTE_OFFSET = 2; // low address bits that select a byte in a word

    typedef logic [31:0] word_t;             // one data word
    typedef logic [31:0] addr_t;             // byte address
    typedef logic [31-BYTE_OFFSET:0] tag_t;  // full word address kept as tag

    // request from the requester
    typedef struct packed {
        logic  we;   // 1 for a write, 0 for a read
        addr_t addr; // byte address of the word
        word_t wd;   // write data, unused on reads
    } cache_req_t;

    // response back to the requester
    typedef struct packed {
        word_t rd;   // word read, or the word written
        logic  hit;  // line was present in either way
    } cache_rsp_t;

    // one stored line in a way
    typedef struct packed {
        logic  valid; // line holds real data
        logic  dirty; // line differs from ram
        tag_t  tag;   // word address of the line
        word_t data;  // the cached word
    } way_line_t;

    // dirty line leaving the cache
    typedef struct packed {
        addr_t addr;  // byte address in ram
        word_t data;  // evicted word
    } wb_t;

endpackage

`default_nettype wire

/* cache_way_store.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_way_store #(
    parameter int NUM_SETS = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(NUM_SETS)-1:0] rd_set,  // set looked up this cycle
    output cache_pkg::way_line_t        rd_line, // registered line, one cycle later
    input  logic                        wr_en,
    input  logic [$clog2(NUM_SETS)-1:0] wr_set,
    input  cache_pkg::way_line_t        wr_line
);

    logic [NUM_SETS-1:0] valid_q;              // valid bits, cleared by reset
    logic                dirty_mem [NUM_SETS];
    cache_pkg::tag_t     tag_mem   [NUM_SETS];
    cache_pkg::word_t    data_mem  [NUM_SETS];

    logic                rd_valid_q;
    logic                rd_dirty_q;
    cache_pkg::tag_t     rd_tag_q;
    cache_pkg::word_t    rd_data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;                 // whole way invalid
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_set] <= wr_line.valid;
            end
            rd_valid_q <= valid_q[rd_set];    // old value on a same-set write
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            dirty_mem[wr_set] <= wr_line.dirty;
            tag_mem[wr_set]   <= wr_line.tag;
            data_mem[wr_set]  <= wr_line.data;
        end
        rd_dirty_q <= dirty_mem[rd_set];      // read before write
        rd_tag_q   <= tag_mem[rd_set];
        rd_data_q  <= data_mem[rd_set];
    end

    always_comb begin
        rd_line.valid = rd_valid_q;
        rd_line.dirty = rd_dirty_q;
        rd_line.tag   = rd_tag_q;
        rd_line.data  = rd_data_q;
    end

endmodule

`default_nettype wire

/* list.f */
cache_pkg.sv
cache_way_store.sv
two_way_cache_controller.sv
two_way_cache_top.sv
two_way_cache_properties.sv
tb_two_way_cache.sv

/* tb_two_way_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_two_way_cache;

    localparam int NUM_SETS    = 16;
    localparam int CREDITS     = 2;
    localparam int MAX_WAIT    = 100; // cycles before a wait gives up
    localparam int EXPECTED_WB = 4;   // dirty evictions in cache_input.txt

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    cache_pkg::cache_req_t req;
    logic                  credit_return;
    logic                  rsp_valid;
    cache_pkg::cache_rsp_t rsp;
    cache_pkg::addr_t      mem_rd_addr;
    cache_pkg::word_t      mem_rd_data;
    logic                  wb_valid;
    cache_pkg::wb_t        wb;

    cache_pkg::word_t      ram [cache_pkg::tag_t];     // backing ram, by word address
    cache_pkg::word_t      written [cache_pkg::tag_t]; // last word issued per address
    cache_pkg::cache_req_t stim_q [$];
    cache_pkg::cache_rsp_t expect_q [$];               // expected responses in order

    int     issued          = 0;
    int     returned        = 0;  // credits handed back so far
    int     rsp_idx         = 0;
    int     wb_count        = 0;
    int     mismatch_count  = 0;
    int     protocol_errors = 0;
    logic   req_d1          = 1'b0;
    logic   req_d2          = 1'b0; // req_valid two edges back
    cache_pkg::addr_t addr_d1 = '0; // request address one edge back
    integer seed            = 32'hadfb5185;

    two_way_cache_top #(
        .NUM_SETS(NUM_SETS),
        .CREDITS(CREDITS)
    ) DUT (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req(req),
        .credit_return(credit_return),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_data(mem_rd_data),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    always_comb begin
        if (ram.exists(mem_rd_addr[31:2])) begin
            mem_rd_data = ram[mem_rd_addr[31:2]];
        end else begin
            mem_rd_data = {2'b00, mem_rd_addr[31:2]} ^ 32'h5a5a0000; // untouched word
        end
    end

    always @(posedge clk) begin
        if (rst_n && wb_valid) begin
            ram[wb.addr[31:2]] = wb.data; // write-back lands at the edge
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count = mismatch_count + 1;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic load_stimulus(output logic ok);
        int                    fd;
        int                    n;
        string                 line;
        logic [7:0]            op;
        cache_pkg::addr_t      addr;
        cache_pkg::word_t      wd;
        cache_pkg::word_t      exp_rd;
        logic [31:0]           exp_hit;
        cache_pkg::cache_req_t r;
        cache_pkg::cache_rsp_t e;
        fd = $fopen("cache_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin   // skip the column notes
                    n = $sscanf(line, "%c %h %h %h %h", op, addr, wd, exp_rd, exp_hit);
                    if (n == 5) begin
                        r.we   = (op == "W");
                        r.addr = addr;
                        r.wd   = wd;
                        e.rd   = exp_rd;
                        e.hit  = exp_hit[0];
                        stim_q.push_back(r);
                        expect_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (stim_q.size() > 0);
    endtask

    task automatic issue_requests(output logic timed_out);
        int idle;
        int waited;
        timed_out = 1'b0;
        for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
            idle = {$random(seed)} % 3;            // 0 to 2 idle cycles
            repeat (idle) @(negedge clk);
            waited = 0;
            while ((issued - returned) >= CREDITS && waited < MAX_WAIT) begin
                @(negedge clk);
                waited++;
            end
            if ((issued - returned) >= CREDITS) begin
                $display("timed out waiting for a credit before request %0d", i);
                timed_out = 1'b1;
            end else begin
                req_valid = 1'b1;
                req       = stim_q[i];
                if (stim_q[i].we) begin
                    written[stim_q[i].addr[31:2]] = stim_q[i].wd;
                end
                issued++;                          // one credit spent
                @(negedge clk);
                req_valid = 1'b0;
                req       = '0;
            end
        end
    endtask

    always @(posedge clk) begin : response_monitor
        if (rst_n) begin
            check_value("rsp_valid", 32'(rsp_valid), 32'(req_d2));
            check_value("credit_return", 32'(credit_return), 32'(req_d2));
            if (req_d1) begin
                check_value("mem_rd_addr", mem_rd_addr, addr_d1 & 32'hffff_fffc); // word aligned
            end
            if (credit_return) begin
                returned = returned + 1;
            end
            if (rsp_valid) begin
                if (rsp_idx >= expect_q.size()) begin
                    protocol_errors = protocol_errors + 1;
                    $display("a response arrived with no request outstanding");
                end else begin
                    check_value("rsp.rd", rsp.rd, expect_q[rsp_idx].rd);
                    check_value("rsp.hit", 32'(rsp.hit), 32'(expect_q[rsp_idx].hit));
                end
                rsp_idx = rsp_idx + 1;
            end
            if (wb_valid) begin
                wb_count = wb_count + 1;
                if (written.exists(wb.addr[31:2])) begin
                    check_value("wb.data", wb.data, written[wb.addr[31:2]]);
                end else begin
                    protocol_errors = protocol_errors + 1;
                    $display("write-back of address %h that was never written", wb.addr);
                end
            end
        end
        req_d2  = req_d1;
        req_d1  = req_valid;
        addr_d1 = req.addr;
    end

    initial begin : stimulus
        logic load_ok;
        logic timed_out;
        logic failed;
        int   waited;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        timed_out = 1'b0;
        load_stimulus(load_ok);
        if (load_ok) begin
            repeat (3) @(posedge clk);             // reset held 3 cycles
            @(negedge clk);
            rst_n = 1'b1;
            issue_requests(timed_out);
            waited = 0;
            while (!timed_out && rsp_idx < stim_q.size() && waited < MAX_WAIT) begin
                @(negedge clk);
                waited++;
            end
            if (!timed_out && rsp_idx < stim_q.size()) begin
                $display("timed out waiting for responses, %0d of %0d seen",
                         rsp_idx, stim_q.size());
                timed_out = 1'b1;
            end
            repeat (3) @(negedge clk);             // catch stray responses
            check_value("write-back count", 32'(wb_count), 32'(EXPECTED_WB));
            check_value("credit_return count", 32'(returned), 32'(issued));
        end else begin
            $display("no requests could be read from cache_input.txt");
        end
        failed = !load_ok || timed_out || (mismatch_count != 0) || (protocol_errors != 0);
        $display("errors: %0d value mismatches, %0d protocol errors, %0d timeouts",
                 mismatch_count, protocol_errors, timed_out);
        if (failed) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* two_way_cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module two_way_cache_controller #(
    parameter int NUM_SETS = 16,
    parameter int CREDITS  = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  cache_pkg::cache_req_t       req,
    input  cache_pkg::way_line_t        way0_line,   // way 0 read, compare cycle
    input  cache_pkg::way_line_t        way1_line,   // way 1 read, compare cycle
    input  cache_pkg::word_t            mem_rd_data, // combinational ram read
    output logic                        way0_wr_en,
    output logic                        way1_wr_en,
    output logic [$clog2(NUM_SETS)-1:0] wr_set,
    output cache_pkg::way_line_t        wr_line,
    output cache_pkg::addr_t            mem_rd_addr,
    output logic                        wb_valid,
    output cache_pkg::wb_t              wb,
    output logic                        rsp_valid,
    output cache_pkg::cache_rsp_t       rsp,
    output logic                        credit_return
);

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int CNT_W = $clog2(CREDITS + 1);

    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [CNT_W-1:0] credit_cnt_t;

    logic                  req_valid_q;  // request in compare cycle
    cache_pkg::cache_req_t req_q;
    set_idx_t              req_set;
    cache_pkg::tag_t       req_tag;

    logic                  fwd_valid_q;  // previous request wrote a line
    set_idx_t              fwd_set_q;
    logic                  fwd_way_q;
    cache_pkg::way_line_t  fwd_line_q;
    logic                  fwd_match;

    cache_pkg::way_line_t  way0_eff;
    cache_pkg::way_line_t  way1_eff;
    cache_pkg::way_line_t  sel_line;
    logic                  hit0;
    logic                  hit1;
    logic                  hit;
    logic                  victim_way;
    logic                  target_way;
    logic                  wr_any;
    logic [NUM_SETS-1:0]   lru_q;        // 1 bit per set, names the lru way
    cache_pkg::cache_rsp_t rsp_d;
    credit_cnt_t           credit_cnt_q; // credits held by the requester

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;                    // sampled with the way reads
    end

    assign req_set = req_q.addr[cache_pkg::BYTE_OFFSET +: SET_W];
    assign req_tag = req_q.addr[$bits(cache_pkg::addr_t)-1:cache_pkg::BYTE_OFFSET];

    // way store read missed last cycle's write, so take the line just written
    assign fwd_match = fwd_valid_q && (fwd_set_q == req_set);
    assign way0_eff  = (fwd_match && !fwd_way_q) ? fwd_line_q : way0_line;
    assign way1_eff  = (fwd_match && fwd_way_q) ? fwd_line_q : way1_line;

    assign hit0       = way0_eff.valid && (way0_eff.tag == req_tag);
    assign hit1       = way1_eff.valid && (way1_eff.tag == req_tag);
    assign hit        = hit0 || hit1;
    assign victim_way = lru_q[req_set];
    assign target_way = hit ? hit1 : victim_way;      // hit way or lru victim
    assign sel_line   = target_way ? way1_eff : way0_eff;

    assign mem_rd_addr = {req_tag, {cache_pkg::BYTE_OFFSET{1'b0}}};
    assign wb_valid    = req_valid_q && !hit && sel_line.valid && sel_line.dirty;
    assign wb.addr     = {sel_line.tag, {cache_pkg::BYTE_OFFSET{1'b0}}};
    assign wb.data     = sel_line.data;

    assign wr_any     = req_valid_q && (req_q.we || !hit); // read hit leaves line as is
    assign way0_wr_en = wr_any && !target_way;
    assign way1_wr_en = wr_any && target_way;
    assign wr_set     = req_set;

    always_comb begin
        wr_line.valid = 1'b1;
        wr_line.dirty = req_q.we;                          // refill is clean
        wr_line.tag   = req_tag;
        wr_line.data  = req_q.we ? req_q.wd : mem_rd_data;
        rsp_d.hit     = hit;
        if (req_q.we) begin
            rsp_d.rd = req_q.wd;                           // echo the written word
        end else if (hit) begin
            rsp_d.rd = sel_line.data;
        end else begin
            rsp_d.rd = mem_rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q         <= '0;                           // way 0 is first victim
            fwd_valid_q   <= 1'b0;
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid_q) begin
                lru_q[req_set] <= ~target_way;             // other way becomes lru
            end
            fwd_valid_q   <= wr_any;
            rsp_valid     <= req_valid_q;
            credit_return <= req_valid_q;                  // one credit per response
        end
    end

    always_ff @(posedge clk) begin
        fwd_set_q  <= req_set;
        fwd_way_q  <= target_way;
        fwd_line_q <= wr_line;
        rsp        <= rsp_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt_q <= credit_cnt_t'(CREDITS);
        end else begin
            case ({req_valid, credit_return})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1; // request spends one
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1; // response gives one back
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* two_way_cache_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module two_way_cache_properties #(
    parameter int CREDITS = 2
) (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         req_valid,
    input logic                         rsp_valid,
    input logic                         wb_valid,
    input cache_pkg::wb_t               wb,          // evicted line
    input cache_pkg::addr_t             mem_rd_addr, // line being looked up
    input logic [$clog2(CREDITS+1)-1:0] credit_cnt
);

    credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credit_cnt) <= CREDITS)
        else $error("credit count %0d outside 0 to %0d", credit_cnt, CREDITS);

    rsp_two_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(req_valid, 2))
        else $error("rsp_valid not 2 cycles after req_valid");

    // a victim holding the requested address would have been a hit
    wb_only_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> ($past(req_valid) && (wb.addr != mem_rd_addr)))
        else $error("wb_valid without a miss");

endmodule

bind two_way_cache_controller two_way_cache_properties #(
    .CREDITS(CREDITS)
) controller_props (
    .clk(clk),
    .rst_n(rst_n),
    .req_valid(req_valid),
    .rsp_valid(rsp_valid),
    .wb_valid(wb_valid),
    .wb(wb),
    .mem_rd_addr(mem_rd_addr),
    .credit_cnt(credit_cnt_q)
);

`default_nettype wire

/* two_way_cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module two_way_cache_top #(
    parameter int NUM_SETS = 16, // sets per way
    parameter int CREDITS  = 2   // requests allowed in flight
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  cache_pkg::cache_req_t req,
    output logic                  credit_return,
    output logic                  rsp_valid,
    output cache_pkg::cache_rsp_t rsp,
    output cache_pkg::addr_t      mem_rd_addr,  // ram read address
    input  cache_pkg::word_t      mem_rd_data,  // same-cycle ram data
    output logic                  wb_valid,     // ram writes at next edge
    output cache_pkg::wb_t        wb
);

    localparam int SET_W = $clog2(NUM_SETS);

    logic [SET_W-1:0]     rd_set;     // set of the incoming request
    logic [SET_W-1:0]     wr_set;
    cache_pkg::way_line_t way0_line;
    cache_pkg::way_line_t way1_line;
    cache_pkg::way_line_t wr_line;
    logic                 way0_wr_en;
    logic                 way1_wr_en;

    assign rd_set = req.addr[cache_pkg::BYTE_OFFSET +: SET_W];

    cache_way_store #(
        .NUM_SETS(NUM_SETS)
    ) way0_store (
        .clk(clk),
        .rst_n(rst_n),
        .rd_set(rd_set),
        .rd_line(way0_line),
        .wr_en(way0_wr_en),
        .wr_set(wr_set),
        .wr_line(wr_line)
    );

    cache_way_store #(
        .NUM_SETS(NUM_SETS)
    ) way1_store (
        .clk(clk),
        .rst_n(rst_n),
        .rd_set(rd_set),
        .rd_line(way1_line),
        .wr_en(way1_wr_en),
        .wr_set(wr_set),
        .wr_line(wr_line)     // shared, enables pick the way
    );

    two_way_cache_controller #(
        .NUM_SETS(NUM_SETS),
        .CREDITS(CREDITS)
    ) cache_controller (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req(req),
        .way0_line(way0_line),
        .way1_line(way1_line),
        .mem_rd_data(mem_rd_data),
        .way0_wr_en(way0_wr_en),
        .way1_wr_en(way1_wr_en),
        .wr_set(wr_set),
        .wr_line(wr_line),
        .mem_rd_addr(mem_rd_addr),
        .wb_valid(wb_valid),
        .wb(wb),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .credit_return(credit_return)
    );

endmodule

`default_nettype wire
